// ==== Bender.yml ====
package:
  name: smpc

export_include_dirs:
  - .

sources:
  - smpc_cmd_pkg.sv
  - smpc_port_pkg.sv
  - smpc_oreg_wr_if.sv
  - smpc_host_regs.sv
  - smpc_cmd_exec.sv
  - smpc_pad_scan.sv
  - smpc_oreg_arbiter.sv
  - smpc_top.sv
  - target: simulation
    files:
      - tb_smpc.sv

// ==== smpc.f ====
+incdir+.
smpc_cmd_pkg.sv
smpc_port_pkg.sv
smpc_oreg_wr_if.sv
smpc_host_regs.sv
smpc_cmd_exec.sv
smpc_pad_scan.sv
smpc_oreg_arbiter.sv
smpc_top.sv
tb_smpc.sv

// ==== smpc_cmd_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_cmd_exec import smpc_cmd_pkg::*; (
	input  wire             CLK,
	input  wire             RST_N,
	input  wire             ce,
	smpc_cmd_if.exec        cmd,
	smpc_oreg_wr_if.writer  oreg_wr,
	output logic            scan_start,
	input  wire             scan_done,
	output logic            mshres_n,
	output logic            mshnmi_n,
	output logic            sshres_n,
	output logic            sshnmi_n,
	output logic            sndres_n,
	output logic            cdres_n,
	output logic            mirq_n
);

	localparam int WAIT_W = $clog2(`SMPC_PERI_WAIT + 1);
	localparam int unsigned ECHO_IDX = `SMPC_OREG_CMD_SLOT;

	smpc_exec_st_e     st_q;
	smpc_exec_st_e     next_q;   // Target of WAIT
	logic [WAIT_W-1:0] wait_cnt;
	logic              start_pend;
	logic              echo_pend;
	logic              intback_ok;

	assign intback_ok = cmd.ireg[2] == 8'hF0 && cmd.ireg[1][3] && !cmd.ireg[0][0];

	// Echo of the command byte into the last output register
	assign oreg_wr.req  = (st_q == EX_EXEC) || (st_q == EX_PERI && echo_pend);
	assign oreg_wr.addr = ECHO_IDX[`SMPC_OREG_AW-1:0];
	assign oreg_wr.data = cmd.comreg;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			st_q          <= EX_IDLE;
			next_q        <= EX_IDLE;
			wait_cnt      <= '0;
			start_pend    <= 1'b0;
			echo_pend     <= 1'b0;
			scan_start    <= 1'b0;
			cmd.done      <= 1'b0;
			cmd.peri_done <= 1'b0;
			mshres_n      <= 1'b0;
			mshnmi_n      <= 1'b0;
			sshres_n      <= 1'b0;
			sshnmi_n      <= 1'b0;
			sndres_n      <= 1'b0;
			cdres_n       <= 1'b0;
			mirq_n        <= 1'b1;
		end else begin
			cmd.done      <= 1'b0;
			cmd.peri_done <= 1'b0;
			if (ce) begin
				scan_start <= 1'b0;
				case (st_q)
					EX_IDLE: begin
						if (start_pend) begin
							start_pend <= 1'b0;
							wait_cnt   <= WAIT_W'(`SMPC_CMD_WAIT);
							next_q     <= EX_COMMAND;
							st_q       <= EX_WAIT;
						end
					end
					EX_WAIT: begin
						if (wait_cnt != '0) begin
							wait_cnt <= wait_cnt - 1'b1;
						end else begin
							scan_start <= (next_q == EX_PERI);
							st_q       <= next_q;
						end
					end
					EX_COMMAND: begin
						next_q <= EX_EXEC;
						st_q   <= EX_WAIT;
						case (cmd.comreg)
							CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF, CMD_NMIREQ:
								wait_cnt <= WAIT_W'(`SMPC_EXEC_WAIT_SHORT);
							CMD_CDON, CMD_CDOFF:
								wait_cnt <= WAIT_W'(`SMPC_EXEC_WAIT_CD);
							CMD_INTBACK: begin
								if (intback_ok) begin
									wait_cnt <= WAIT_W'(`SMPC_PERI_WAIT);
									next_q   <= EX_PERI;
								end else begin
									st_q <= EX_END; // No report
								end
							end
							default: st_q <= EX_END;
						endcase
					end
					EX_EXEC: begin
						if (oreg_wr.grant) begin
							case (cmd.comreg)
								CMD_MSHON: begin
									mshres_n <= 1'b1;
									mshnmi_n <= 1'b1;
								end
								CMD_SSHON: begin
									sshres_n <= 1'b1;
									sshnmi_n <= 1'b1;
								end
								CMD_SSHOFF: begin
									sshres_n <= 1'b0;
									sshnmi_n <= 1'b1;
								end
								CMD_SNDON:  sndres_n <= 1'b1;
								CMD_SNDOFF: sndres_n <= 1'b0;
								CMD_CDON:   cdres_n <= 1'b1;
								CMD_CDOFF:  cdres_n <= 1'b0;
								CMD_NMIREQ: mshnmi_n <= 1'b0;
								default: ;
							endcase
							st_q <= EX_END;
						end
					end
					EX_PERI: begin
						if (scan_done) begin
							echo_pend <= 1'b1;
						end else if (echo_pend && oreg_wr.grant) begin
							echo_pend     <= 1'b0;
							mirq_n        <= 1'b0;
							cmd.peri_done <= 1'b1;
							st_q          <= EX_END;
						end
					end
					EX_END: begin
						if (cmd.comreg == CMD_NMIREQ)
							mshnmi_n <= 1'b1;
						mirq_n   <= 1'b1;
						cmd.done <= 1'b1;
						st_q     <= EX_IDLE;
					end
					default: st_q <= EX_IDLE;
				endcase
			end
			if (cmd.cmd_start)
				start_pend <= 1'b1; // Held until a CE cycle in IDLE
		end
	end

endmodule

`default_nettype wire

// ==== smpc_cmd_pkg.sv ====
`default_nettype none

`include "smpc_defines.svh"

package smpc_cmd_pkg;

	typedef enum logic [`SMPC_DATA_W-1:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_NMIREQ  = 8'h18
	} smpc_cmd_e;

	typedef enum logic [2:0] {
		EX_IDLE,
		EX_WAIT,
		EX_COMMAND,
		EX_EXEC,
		EX_PERI,
		EX_END
	} smpc_exec_st_e;

	typedef logic [`SMPC_IREG_NUM-1:0][`SMPC_DATA_W-1:0] smpc_ireg_t; // IREG0 at index 0

endpackage

`default_nettype wire

// ==== smpc_defines.svh ====
`ifndef SMPC_DEFINES_SVH
`define SMPC_DEFINES_SVH

`define SMPC_DATA_W         8
`define SMPC_ADDR_W         6
`define SMPC_OREG_AW        5
`define SMPC_IREG_NUM       7
`define SMPC_PORT_W         7
`define SMPC_TH_BIT         6
`define SMPC_TR_BIT         5

// Host word addresses
`define SMPC_ADDR_COMREG    6'h0F
`define SMPC_ADDR_SR        6'h30
`define SMPC_ADDR_SF        6'h31
`define SMPC_ADDR_OREG_LAST 6'h2F
`define SMPC_OREG_BASE      6'h10

// Wait counts in CE cycles
`define SMPC_CMD_WAIT        60
`define SMPC_EXEC_WAIT_SHORT 60
`define SMPC_EXEC_WAIT_CD    100
`define SMPC_PERI_WAIT       200
`define SMPC_PAD_SETTLE      60

`define SMPC_OREG_CMD_SLOT   31

`endif

// ==== smpc_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_host_regs import smpc_cmd_pkg::*; (
	input  wire                       CLK,
	input  wire                       RST_N,
	input  wire [`SMPC_ADDR_W-1:0]    a,
	input  wire [`SMPC_DATA_W-1:0]    di,
	input  wire                       cs_n,
	input  wire                       rw_n,
	output logic [`SMPC_DATA_W-1:0]   do_q,
	smpc_cmd_if.host                  cmd,
	input  wire [`SMPC_DATA_W-1:0]    oreg_q,
	output logic [`SMPC_OREG_AW-1:0]  oreg_raddr
);

	smpc_ireg_t              ireg_q;
	logic [`SMPC_DATA_W-1:0] comreg_q;
	logic                    start_q;
	logic                    busy_q;  // Executor owns COMREG
	logic                    sf_q;
	logic [2:0]              sr_hi_q;
	logic [`SMPC_DATA_W-1:0] sr;
	logic                    rw_n_old;
	logic                    cs_n_old;
	logic                    wr_stb;
	logic                    rd_stb;
	logic [`SMPC_ADDR_W-1:0] oreg_off;

	assign wr_stb = !rw_n && rw_n_old && !cs_n;
	assign rd_stb = !cs_n && cs_n_old && rw_n;

	assign sr = {sr_hi_q, 1'b0, ireg_q[1][7:4]};

	assign oreg_off   = a - `SMPC_OREG_BASE;
	assign oreg_raddr = oreg_off[`SMPC_OREG_AW-1:0];

	assign cmd.comreg    = comreg_q;
	assign cmd.ireg      = ireg_q;
	assign cmd.cmd_start = start_q;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ireg_q   <= '0;
			comreg_q <= '0;
			start_q  <= 1'b0;
			busy_q   <= 1'b0;
			sf_q     <= 1'b0;
			sr_hi_q  <= '0;
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			do_q     <= '0;
		end else begin
			rw_n_old <= rw_n;
			cs_n_old <= cs_n;
			start_q  <= 1'b0;

			if (cmd.done) begin
				busy_q <= 1'b0;
				sf_q   <= 1'b0;
			end
			if (cmd.peri_done)
				sr_hi_q <= 3'b110;

			if (wr_stb) begin
				if (a < `SMPC_ADDR_W'(`SMPC_IREG_NUM)) begin
					ireg_q[a[2:0]] <= di;
				end else if (a == `SMPC_ADDR_COMREG && !busy_q) begin
					comreg_q <= di;
					start_q  <= 1'b1;
					busy_q   <= 1'b1;
				end else if (a == `SMPC_ADDR_SF && di[0]) begin
					sf_q <= 1'b1; // Host sets SF before COMREG
				end
			end

			if (rd_stb) begin
				if (a >= `SMPC_OREG_BASE && a <= `SMPC_ADDR_OREG_LAST)
					do_q <= oreg_q;
				else if (a == `SMPC_ADDR_SR)
					do_q <= sr;
				else if (a == `SMPC_ADDR_SF)
					do_q <= {4'hF, 3'b000, sf_q};
				else
					do_q <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== smpc_input.txt ====
// cmd ireg0 ireg1 ireg2 pres1 pres2 | port1 n11 n01 n10 n00 | port2 n11 n01 n10 n00
// | lines mirq_pulses nmi_pulses sr | nbytes | oreg0..oreg8
00 00 00 00 0 0 F F F F F F F F 30 0 0 00 0 00 00 00 00 00 00 00 00 00
02 00 00 00 0 0 F F F F F F F F 3C 0 0 00 0 00 00 00 00 00 00 00 00 00
06 00 00 00 0 0 F F F F F F F F 3E 0 0 00 0 00 00 00 00 00 00 00 00 00
08 00 00 00 0 0 F F F F F F F F 3F 0 0 00 0 00 00 00 00 00 00 00 00 00
03 00 00 00 0 0 F F F F F F F F 37 0 0 00 0 00 00 00 00 00 00 00 00 00
07 00 00 00 0 0 F F F F F F F F 35 0 0 00 0 00 00 00 00 00 00 00 00 00
09 00 00 00 0 0 F F F F F F F F 34 0 0 00 0 00 00 00 00 00 00 00 00 00
18 00 00 00 0 0 F F F F F F F F 34 0 1 00 0 00 00 00 00 00 00 00 00 00
10 00 28 F0 1 1 4 F F F C 5 A 3 34 1 0 C2 9 F1 02 FF F7 F1 02 5A 3F F0
10 00 58 F0 1 0 8 A E D F F F F 34 1 0 C5 6 F1 02 AE DF F0 F0 00 00 00
10 00 98 F0 0 1 F F F F 4 7 0 6 34 1 0 C9 6 F0 F1 02 70 67 F0 00 00 00
10 00 08 F0 0 0 F F F F F F F F 34 1 0 C0 3 F0 F0 F0 00 00 00 00 00 00
10 00 F8 F0 1 1 2 3 3 3 4 F 0 0 34 1 0 CF 6 F0 F1 02 F0 07 F0 00 00 00
10 00 08 00 1 1 4 F F F 4 F F F 34 0 0 00 0 00 00 00 00 00 00 00 00 00
10 00 00 F0 1 1 4 F F F 4 F F F 34 0 0 00 0 00 00 00 00 00 00 00 00 00

// ==== smpc_oreg_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_oreg_arbiter (
	input  wire                      CLK,
	smpc_oreg_wr_if.arbiter          scan_wr,
	smpc_oreg_wr_if.arbiter          exec_wr,
	input  wire [`SMPC_OREG_AW-1:0]  raddr,
	output logic [`SMPC_DATA_W-1:0]  q
);

	localparam int DEPTH = 1 << `SMPC_OREG_AW;

	logic [`SMPC_DATA_W-1:0]  oreg [DEPTH];
	logic                     wr_en;
	logic [`SMPC_OREG_AW-1:0] wr_addr;
	logic [`SMPC_DATA_W-1:0]  wr_data;

	// Scanner wins, executor waits
	assign scan_wr.grant = scan_wr.req;
	assign exec_wr.grant = exec_wr.req && !scan_wr.req;

	assign wr_en   = scan_wr.grant || exec_wr.grant;
	assign wr_addr = scan_wr.grant ? scan_wr.addr : exec_wr.addr;
	assign wr_data = scan_wr.grant ? scan_wr.data : exec_wr.data;

	always_ff @(posedge CLK) begin
		if (wr_en)
			oreg[wr_addr] <= wr_data;
	end

	assign q = oreg[raddr]; // Host read port

endmodule

`default_nettype wire

// ==== smpc_oreg_wr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

interface smpc_cmd_if import smpc_cmd_pkg::*; ();
	logic [`SMPC_DATA_W-1:0] comreg;
	smpc_ireg_t              ireg;
	logic                    cmd_start; // Command byte accepted
	logic                    done;      // Clears SF
	logic                    peri_done; // Loads SR[7:5]

	modport host (output comreg, output ireg, output cmd_start, input done, input peri_done);
	modport exec (input comreg, input ireg, input cmd_start, output done, output peri_done);
endinterface

interface smpc_oreg_wr_if ();
	logic                     req;
	logic [`SMPC_OREG_AW-1:0] addr;
	logic [`SMPC_DATA_W-1:0]  data;
	logic                     grant;

	modport writer (output req, output addr, output data, input grant);
	modport arbiter (input req, input addr, input data, output grant);
endinterface

`default_nettype wire

// ==== smpc_pad_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_pad_scan import smpc_port_pkg::*; (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      ce,
	input  wire                      start,
	input  wire [`SMPC_PORT_W-1:0]   pdr1i,
	input  wire [`SMPC_PORT_W-1:0]   pdr2i,
	output logic [`SMPC_PORT_W-1:0]  pdr1o,
	output logic [`SMPC_PORT_W-1:0]  ddr1,
	output logic [`SMPC_PORT_W-1:0]  pdr2o,
	output logic [`SMPC_PORT_W-1:0]  ddr2,
	output logic                     done,
	smpc_oreg_wr_if.writer           oreg_wr
);

	localparam int SETTLE_W = $clog2(`SMPC_PAD_SETTLE + 1);

	smpc_scan_st_e            st_q;
	smpc_scan_st_e            emit_next;
	smpc_pad_nib_t            nib_q;
	logic [3:0]               id_q;
	logic                     port_q;    // 0 is port 1
	logic [SETTLE_W-1:0]      settle_q;
	logic [`SMPC_OREG_AW-1:0] idx_q;
	logic [`SMPC_PORT_W-1:0]  pdr_o [2];
	logic [`SMPC_PORT_W-1:0]  ddr [2];
	logic [3:0]               pin;
	logic [`SMPC_DATA_W-1:0]  emit_data;
	logic                     emit_req;

	assign pin   = port_q ? pdr2i[3:0] : pdr1i[3:0];
	assign pdr1o = pdr_o[0];
	assign pdr2o = pdr_o[1];
	assign ddr1  = ddr[0];
	assign ddr2  = ddr[1];

	assign oreg_wr.req  = emit_req;
	assign oreg_wr.addr = idx_q;
	assign oreg_wr.data = emit_data;

	always_comb begin
		emit_req  = (settle_q == '0);
		emit_data = {DEV_NONE, 4'h0};
		emit_next = SC_NEXT;
		case (st_q)
			SC_RPT_ID: begin
				emit_data = 8'hF1;
				emit_next = SC_RPT_SIZE;
			end
			SC_RPT_SIZE: begin
				emit_data = 8'h02;
				emit_next = SC_RPT_B0;
			end
			SC_RPT_B0: begin
				emit_data = {nib_q.n01, nib_q.n10};
				emit_next = SC_RPT_B1;
			end
			SC_RPT_B1: emit_data = {nib_q.n00, nib_q.n11[3], 3'b111};
			SC_RPT_NONE: ;
			SC_RPT_TERM: emit_next = SC_END; // Closing F0
			default: emit_req = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			st_q     <= SC_IDLE;
			id_q     <= '0;
			port_q   <= 1'b0;
			settle_q <= '0;
			idx_q    <= '0;
			done     <= 1'b0;
			pdr_o    <= '{default: '1};
			ddr      <= '{default: '0};
		end else if (ce) begin
			done <= 1'b0;
			if (settle_q != '0) begin
				settle_q <= settle_q - 1'b1;
			end else begin
				case (st_q)
					SC_IDLE: ;
					SC_START: begin
						ddr[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b11;
						st_q <= SC_ID_0;
					end
					SC_ID_0: begin
						pdr_o[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b11;
						settle_q <= SETTLE_W'(`SMPC_PAD_SETTLE);
						st_q     <= SC_ID_1;
					end
					SC_ID_1: st_q <= SC_ID_2;
					SC_ID_2: begin
						pdr_o[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b01;
						settle_q <= SETTLE_W'(`SMPC_PAD_SETTLE);
						st_q     <= SC_ID_3;
					end
					SC_ID_3: st_q <= SC_ID_4;
					SC_ID_4: begin
						id_q <= {|nib_q.n11[3:2], |nib_q.n11[1:0], |nib_q.n01[3:2], |nib_q.n01[1:0]};
						st_q <= SC_TYPE_SEL;
					end
					SC_TYPE_SEL: st_q <= (id_q == DEV_PAD) ? SC_PAD_0 : SC_RPT_NONE;
					SC_PAD_0: begin
						pdr_o[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b10;
						settle_q <= SETTLE_W'(`SMPC_PAD_SETTLE);
						st_q     <= SC_PAD_1;
					end
					SC_PAD_1: st_q <= SC_PAD_2;
					SC_PAD_2: begin
						pdr_o[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b00;
						settle_q <= SETTLE_W'(`SMPC_PAD_SETTLE);
						st_q     <= SC_PAD_3;
					end
					SC_PAD_3: st_q <= SC_RPT_ID;
					SC_RPT_ID, SC_RPT_SIZE, SC_RPT_B0, SC_RPT_B1, SC_RPT_NONE, SC_RPT_TERM: begin
						if (oreg_wr.grant) begin
							idx_q <= idx_q + 1'b1;
							st_q  <= emit_next;
						end
					end
					SC_NEXT: begin
						pdr_o[port_q][`SMPC_TH_BIT:`SMPC_TR_BIT] <= 2'b11; // Back to idle select
						settle_q <= SETTLE_W'(`SMPC_PAD_SETTLE);
						port_q   <= ~port_q;
						st_q     <= port_q ? SC_RPT_TERM : SC_START;
					end
					SC_END: begin
						done <= 1'b1;
						st_q <= SC_IDLE;
					end
					default: st_q <= SC_IDLE;
				endcase
			end
			if (start) begin
				port_q <= 1'b0;
				idx_q  <= '0;
				st_q   <= SC_START;
			end
		end
	end

	// Nibble capture at the end of each settle period
	always_ff @(posedge CLK) begin
		if (ce && settle_q == '0) begin
			case (st_q)
				SC_ID_1:  nib_q.n11 <= pin;
				SC_ID_3:  nib_q.n01 <= pin;
				SC_PAD_1: nib_q.n10 <= pin;
				SC_PAD_3: nib_q.n00 <= pin;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== smpc_port_pkg.sv ====
`default_nettype none

package smpc_port_pkg;

	typedef enum logic [4:0] {
		SC_IDLE,
		SC_START,
		SC_ID_0, SC_ID_1, SC_ID_2, SC_ID_3, SC_ID_4,
		SC_TYPE_SEL,
		SC_PAD_0, SC_PAD_1, SC_PAD_2, SC_PAD_3,
		SC_RPT_ID, SC_RPT_SIZE, SC_RPT_B0, SC_RPT_B1, SC_RPT_NONE,
		SC_NEXT,
		SC_RPT_TERM,
		SC_END
	} smpc_scan_st_e;

	typedef enum logic [3:0] {
		DEV_PAD  = 4'hB,
		DEV_NONE = 4'hF
	} smpc_dev_id_e;

	// Nibble names follow the TH/TR levels of the phase
	typedef struct packed {
		logic [3:0] n11;
		logic [3:0] n01;
		logic [3:0] n10;
		logic [3:0] n00;
	} smpc_pad_nib_t;

endpackage

`default_nettype wire

// ==== smpc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module smpc_top (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      CE,

	input  wire [`SMPC_ADDR_W-1:0]   A,
	input  wire [`SMPC_DATA_W-1:0]   DI,
	output logic [`SMPC_DATA_W-1:0]  DO,
	input  wire                      CS_N,
	input  wire                      RW_N,

	output logic                     MSHRES_N,
	output logic                     MSHNMI_N,
	output logic                     SSHRES_N,
	output logic                     SSHNMI_N,
	output logic                     SNDRES_N,
	output logic                     CDRES_N,
	output logic                     MIRQ_N,

	input  wire [`SMPC_PORT_W-1:0]   PDR1I,
	output logic [`SMPC_PORT_W-1:0]  PDR1O,
	output logic [`SMPC_PORT_W-1:0]  DDR1,
	input  wire [`SMPC_PORT_W-1:0]   PDR2I,
	output logic [`SMPC_PORT_W-1:0]  PDR2O,
	output logic [`SMPC_PORT_W-1:0]  DDR2
);

	logic [`SMPC_DATA_W-1:0]  oreg_q;
	logic [`SMPC_OREG_AW-1:0] oreg_raddr;
	logic                     scan_start;
	logic                     scan_done;

	smpc_cmd_if     cmd_if ();
	smpc_oreg_wr_if scan_wr_if ();
	smpc_oreg_wr_if exec_wr_if ();

	smpc_host_regs i_host_regs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.a          (A),
		.di         (DI),
		.cs_n       (CS_N),
		.rw_n       (RW_N),
		.do_q       (DO),
		.cmd        (cmd_if.host),
		.oreg_q     (oreg_q),
		.oreg_raddr (oreg_raddr)
	);

	smpc_cmd_exec i_cmd_exec (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.ce         (CE),
		.cmd        (cmd_if.exec),
		.oreg_wr    (exec_wr_if.writer),
		.scan_start (scan_start),
		.scan_done  (scan_done),
		.mshres_n   (MSHRES_N),
		.mshnmi_n   (MSHNMI_N),
		.sshres_n   (SSHRES_N),
		.sshnmi_n   (SSHNMI_N),
		.sndres_n   (SNDRES_N),
		.cdres_n    (CDRES_N),
		.mirq_n     (MIRQ_N)
	);

	smpc_pad_scan i_pad_scan (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.ce      (CE),
		.start   (scan_start),
		.pdr1i   (PDR1I),
		.pdr2i   (PDR2I),
		.pdr1o   (PDR1O),
		.ddr1    (DDR1),
		.pdr2o   (PDR2O),
		.ddr2    (DDR2),
		.done    (scan_done),
		.oreg_wr (scan_wr_if.writer)
	);

	smpc_oreg_arbiter i_oreg_arbiter (
		.CLK     (CLK),
		.scan_wr (scan_wr_if.arbiter),
		.exec_wr (exec_wr_if.arbiter),
		.raddr   (oreg_raddr),
		.q       (oreg_q)
	);

endmodule

`default_nettype wire

// ==== tb_smpc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "smpc_defines.svh"

module tb_smpc;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_TESTS  = 15;
	localparam int FIELDS     = 28; // Tokens per line of smpc_input.txt
	localparam int PER_TEST_CYCLES = `SMPC_CMD_WAIT + `SMPC_EXEC_WAIT_CD + `SMPC_PERI_WAIT
		+ 10 * `SMPC_PAD_SETTLE + 600;
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + 1) * PER_TEST_CYCLES + 50;

	logic                     CLK;
	logic                     RST_N;
	logic                     CE;
	logic [`SMPC_ADDR_W-1:0]  A;
	logic [`SMPC_DATA_W-1:0]  DI;
	wire  [`SMPC_DATA_W-1:0]  DO;
	logic                     CS_N;
	logic                     RW_N;
	wire                      MSHRES_N;
	wire                      MSHNMI_N;
	wire                      SSHRES_N;
	wire                      SSHNMI_N;
	wire                      SNDRES_N;
	wire                      CDRES_N;
	wire                      MIRQ_N;
	wire  [`SMPC_PORT_W-1:0]  PDR1I;
	wire  [`SMPC_PORT_W-1:0]  PDR1O;
	wire  [`SMPC_PORT_W-1:0]  DDR1;
	wire  [`SMPC_PORT_W-1:0]  PDR2I;
	wire  [`SMPC_PORT_W-1:0]  PDR2O;
	wire  [`SMPC_PORT_W-1:0]  DDR2;

	logic [7:0]  vec [0:NUM_TESTS*FIELDS-1];
	logic        pres1;
	logic        pres2;
	logic [15:0] nibs1; // n11, n01, n10, n00
	logic [15:0] nibs2;
	logic [31:0] rng_state = 32'd33644;
	int          cycle_cnt = 0;
	int          mirq_falls = 0;
	int          mirq_low_cycles = 0;
	int          nmi_falls = 0;
	logic        mirq_prev = 1'b1;
	logic        nmi_prev = 1'b0;
	bit          test_ok;
	int          tests_run = 0;
	int          tests_failed = 0;

	smpc_top i_smpc_top (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.A        (A),
		.DI       (DI),
		.DO       (DO),
		.CS_N     (CS_N),
		.RW_N     (RW_N),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N),
		.PDR1I    (PDR1I),
		.PDR1O    (PDR1O),
		.DDR1     (DDR1),
		.PDR2I    (PDR2I),
		.PDR2O    (PDR2O),
		.DDR2     (DDR2)
	);

	// Pad model, nibble picked by the TH/TR select lines
	function automatic logic [3:0] pad_nibble(input logic present, input logic [15:0] nibs,
		input logic [1:0] sel);
		if (!present)
			return 4'hF; // Nothing connected
		case (sel)
			2'b11:   return nibs[15:12];
			2'b01:   return nibs[11:8];
			2'b10:   return nibs[7:4];
			default: return nibs[3:0];
		endcase
	endfunction

	assign PDR1I = {3'b111,
		pad_nibble(pres1, nibs1, {PDR1O[`SMPC_TH_BIT], PDR1O[`SMPC_TR_BIT]})};
	assign PDR2I = {3'b111,
		pad_nibble(pres2, nibs2, {PDR2O[`SMPC_TH_BIT], PDR2O[`SMPC_TR_BIT]})};

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	always @(posedge CLK)
		cycle_cnt <= cycle_cnt + 1;

	// Pulse monitor on the falling clock edge
	always @(negedge CLK) begin
		if (RST_N) begin
			if (!MIRQ_N)
				mirq_low_cycles++;
			if (mirq_prev && !MIRQ_N)
				mirq_falls++;
			if (nmi_prev && !MSHNMI_N)
				nmi_falls++;
		end
		mirq_prev = MIRQ_N;
		nmi_prev  = MSHNMI_N;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic idle_gap();
		int n;
		rng_state = xorshift32(rng_state);
		n = rng_state % 4;
		repeat (n) @(posedge CLK);
	endtask

	task automatic host_write(input logic [`SMPC_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge CLK);
		#1;
		A    = addr;
		DI   = data;
		CS_N = 1'b0;
		RW_N = 1'b0;
		@(posedge CLK);
		#1;
		CS_N = 1'b1;
		RW_N = 1'b1;
		idle_gap();
	endtask

	task automatic host_read(input logic [`SMPC_ADDR_W-1:0] addr, output logic [7:0] data);
		@(posedge CLK);
		#1;
		A    = addr;
		CS_N = 1'b0;
		RW_N = 1'b1;
		@(posedge CLK); // DO latched here
		#1;
		data = DO;
		CS_N = 1'b1;
		idle_gap();
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		test_ok = 1'b0;
	endtask

	task automatic record_result(input string label);
		tests_run++;
		if (test_ok) begin
			$display("Test %0d %s ok", tests_run, label);
		end else begin
			tests_failed++;
			$display("Test %0d %s has errors", tests_run, label);
		end
	endtask

	task automatic check_reset_state();
		logic [7:0] rd;
		test_ok = 1'b1;
		if ({MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N} !== 6'h00)
			report_mismatch("reset/NMI lines",
				{MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N}, 6'h00);
		if (MIRQ_N !== 1'b1)
			report_mismatch("MIRQ_N", MIRQ_N, 1'b1);
		if (PDR1O !== 7'h7F)
			report_mismatch("PDR1O", PDR1O, 7'h7F);
		if (PDR2O !== 7'h7F)
			report_mismatch("PDR2O", PDR2O, 7'h7F);
		if (DDR1 !== 7'h00)
			report_mismatch("DDR1", DDR1, 7'h00); // Ports start as inputs
		if (DDR2 !== 7'h00)
			report_mismatch("DDR2", DDR2, 7'h00);
		host_read(`SMPC_ADDR_SF, rd);
		if (rd !== 8'hF0)
			report_mismatch("SF", rd, 8'hF0);
		record_result("reset state");
	endtask

	task automatic run_test(input int t);
		int         base;
		int         nbytes;
		int         m_falls0;
		int         m_low0;
		int         n_falls0;
		int         t0;
		logic [7:0] cmd_code;
		logic [7:0] rd;
		logic [5:0] lines;
		base     = t * FIELDS;
		cmd_code = vec[base];
		pres1    = vec[base+4][0];
		pres2    = vec[base+5][0];
		nibs1    = {vec[base+6][3:0], vec[base+7][3:0], vec[base+8][3:0], vec[base+9][3:0]};
		nibs2    = {vec[base+10][3:0], vec[base+11][3:0], vec[base+12][3:0], vec[base+13][3:0]};
		nbytes   = vec[base+18];
		test_ok  = 1'b1;
		m_falls0 = mirq_falls;
		m_low0   = mirq_low_cycles;
		n_falls0 = nmi_falls;

		host_write(6'd0, vec[base+1]);
		host_write(6'd1, vec[base+2]);
		host_write(6'd2, vec[base+3]);
		host_write(`SMPC_ADDR_SF, 8'h01);
		host_write(`SMPC_ADDR_COMREG, cmd_code);

		t0 = cycle_cnt;
		host_read(`SMPC_ADDR_SF, rd);
		while (rd[0] && (cycle_cnt - t0) < PER_TEST_CYCLES)
			host_read(`SMPC_ADDR_SF, rd);
		if (rd[0]) begin
			$display("Command %h did not finish, SF still set after %0d cycles",
				cmd_code, PER_TEST_CYCLES);
			test_ok = 1'b0;
		end else if (rd !== 8'hF0) begin
			report_mismatch("SF", rd, 8'hF0);
		end

		lines = {MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N};
		if (lines !== vec[base+14][5:0])
			report_mismatch("reset/NMI lines", lines, vec[base+14][5:0]);
		if (mirq_falls - m_falls0 != vec[base+15])
			report_mismatch("MIRQ_N pulses", mirq_falls - m_falls0, vec[base+15]);
		if (mirq_low_cycles - m_low0 != vec[base+15])
			report_mismatch("MIRQ_N low cycles", mirq_low_cycles - m_low0, vec[base+15]);
		if (nmi_falls - n_falls0 != vec[base+16])
			report_mismatch("MSHNMI_N pulses", nmi_falls - n_falls0, vec[base+16]);

		for (int k = 0; k < nbytes; k++) begin
			host_read(`SMPC_ADDR_W'(`SMPC_OREG_BASE + k), rd);
			if (rd !== vec[base+19+k])
				report_mismatch($sformatf("OREG%0d", k), rd, vec[base+19+k]);
		end
		if (nbytes > 0) begin
			host_read(`SMPC_ADDR_W'(`SMPC_OREG_BASE + `SMPC_OREG_CMD_SLOT), rd);
			if (rd !== cmd_code)
				report_mismatch("OREG31", rd, cmd_code);
			host_read(`SMPC_ADDR_SR, rd);
			if (rd !== vec[base+17])
				report_mismatch("SR", rd, vec[base+17]);
		end

		if (PDR1O !== 7'h7F)
			report_mismatch("PDR1O", PDR1O, 7'h7F); // Idle select
		if (PDR2O !== 7'h7F)
			report_mismatch("PDR2O", PDR2O, 7'h7F);
		record_result($sformatf("cmd %h", cmd_code));
	endtask

	initial begin
		RST_N = 1'b0;
		CE    = 1'b1;
		A     = '0;
		DI    = '0;
		CS_N  = 1'b1;
		RW_N  = 1'b1;
		pres1 = 1'b0;
		pres2 = 1'b0;
		nibs1 = '1;
		nibs2 = '1;
		$readmemh("smpc_input.txt", vec);

		repeat (5) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		repeat (2) @(posedge CLK);

		check_reset_state();
		if ($isunknown(vec[NUM_TESTS*FIELDS-1])) begin
			$display("Stimulus file smpc_input.txt is missing or too short");
			tests_failed++;
		end else begin
			for (int t = 0; t < NUM_TESTS; t++)
				run_test(t);
		end

		$display("Tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
